/* files.f */
+incdir+bench
verilog/blit_pkg.sv
verilog/blit_ifs.sv
verilog/mcu_port.sv
verilog/font_expander.sv
verilog/mem_cmd_issuer.sv
verilog/command_seq.sv
verilog/blit_top.sv
bench/tb_top.sv

/* run.sh */
#!/bin/sh
# build tb_top with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --Wno-fatal -j 0 \
    --top-module tb_top -Mdir obj_dir -f files.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_top)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Test completed successfully"; then
    exit 0
fi
exit 1

/* bench/mcu_tasks.svh */
localparam int strobe_hold = 2;     // 4-cycle strobe outlasts the 3-cycle sync delay

task automatic hold(input int n);
    repeat (n) @(negedge dma_clk);
endtask

// one mcu_clk pulse, long enough for the sequencer to react
task automatic strobe();
    mcu_clk = 1'b1;
    hold(strobe_hold);
    mcu_clk = 1'b0;
    hold(strobe_hold);
endtask

task automatic send_frame();
    mcu_dir = 1'b1;
    hold(strobe_hold);
    foreach (tx_bytes[i]) begin
        mcu_din = tx_bytes[i];          // stable before the rising strobe
        strobe();
    end
    mcu_dir = 1'b0;                     // byte count decoded on this edge
    hold(1);
endtask

task automatic wait_not_busy();
    while (mcu_dout[blit_pkg::status_busy_bit]) begin
        @(negedge dma_clk);
    end
endtask

// buffer bytes 4..35 after a read has reached ready
task automatic read_back();
    rx_bytes.delete();
    strobe();                           // first pulse enters readout
    repeat (32) begin
        rx_bytes.push_back(mcu_dout);
        strobe();
    end
endtask

task automatic push_addr(input logic [blit_pkg::addr_w-1:0] a);
    tx_bytes.delete();
    for (int i = 0; i < 4; i++) begin
        tx_bytes.push_back(8'(32'(a) >> (8 * i)));  // little endian
    end
endtask

/* bench/tb_top.sv */
`timescale 1ns/1ps

module tb_top;

    // about 275 strobes of 4 cycles plus bursts and waits
    localparam int timeout_cycles = 20000;

    logic                          dma_clk;
    logic                          rst_n;
    logic [7:0]                    mcu_din;
    logic                          mcu_clk;
    logic                          mcu_dir;
    logic [blit_pkg::word_w-1:0]   mem_rd_data;
    logic                          mem_rd_data_valid;
    logic                          mem_init_calib;
    logic [7:0]                    mcu_dout;
    logic                          mem_cmd;
    logic                          mem_cmd_en;
    logic [blit_pkg::addr_w-1:0]   mem_addr;
    logic [blit_pkg::word_w-1:0]   mem_wr_data;
    logic [blit_pkg::word_w/8-1:0] mem_data_mask;

    logic [31:0] mem_model [logic [19:0]];
    logic [7:0]  tx_bytes [$];
    logic [7:0]  rx_bytes [$];
    int          cycle_cnt = 0;
    int          cmd_gap   = 1000;      // cycles since last mem_cmd_en

    blit_top DUT (.*);

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    `include "mcu_tasks.svh"

    function automatic logic [31:0] mem_peek(input logic [19:0] a);
        if (mem_model.exists(a)) begin
            return mem_model[a];
        end
        return {12'ha5c, a};            // fill pattern over the whole address
    endfunction

    task automatic check_word(input logic [19:0] a, input logic [31:0] exp);
        assert (mem_peek(a) == exp) else begin
            abort_run($sformatf("Mismatch mem_model[%05h]: got %08h expected %08h",
                                a, mem_peek(a), exp));
        end
    endtask

    initial begin
        dma_clk = 1'b0;
        forever #2 dma_clk = ~dma_clk;
    end

    initial begin
        mem_init_calib = 1'b0;
        @(posedge rst_n);
        repeat (40) @(negedge dma_clk);
        mem_init_calib = 1'b1;
    end

    always @(posedge dma_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        cmd_gap   <= mem_cmd_en ? 1 : cmd_gap + 1;
        if (cycle_cnt == timeout_cycles) begin
            abort_run($sformatf("run did not finish within %0d cycles", timeout_cycles));
        end
    end

    // ========================================================================
    // burst memory model
    // ========================================================================
    initial begin : mem_port
        logic [19:0] wr_addr;
        logic [19:0] rd_addr;
        int          wr_left;
        int          rd_left;
        int          rd_wait;
        mem_rd_data       = '0;
        mem_rd_data_valid = 1'b0;
        wr_left = 0;
        rd_left = 0;
        rd_wait = 0;
        forever begin
            @(negedge dma_clk);
            mem_rd_data_valid = 1'b0;
            if (mem_cmd_en && mem_cmd) begin
                wr_addr = mem_addr;
                wr_left = 8;            // beat 0 is already on the bus
            end
            if (wr_left > 0) begin
                if (mem_data_mask == '0) begin
                    mem_model[wr_addr + 20'(4 * (8 - wr_left))] = mem_wr_data;
                end else if (mem_data_mask != '1) begin
                    abort_run("write beat mask is only partly set");
                end
                wr_left--;
            end
            if (mem_cmd_en && !mem_cmd) begin
                rd_addr = mem_addr;
                rd_left = 8;
                rd_wait = 1 + int'($urandom % 9);   // 2..10 cycles to first beat
            end else if (rd_left > 0) begin
                if (rd_wait > 0) begin
                    rd_wait--;
                end else begin
                    mem_rd_data_valid = 1'b1;
                    mem_rd_data       = mem_peek(rd_addr + 20'(4 * (8 - rd_left)));
                    rd_left--;
                end
            end
        end
    end

    no_cmd_before_calib: assert property (@(posedge dma_clk) disable iff (!rst_n)
        !mem_init_calib |-> !mem_cmd_en)
        else abort_run("mem_cmd_en issued before memory calibration");
    cmd_spacing: assert property (@(posedge dma_clk) disable iff (!rst_n)
        mem_cmd_en |-> cmd_gap >= blit_pkg::guard_cycles)
        else abort_run("mem_cmd_en issued inside the guard window");

    // ========================================================================
    // command checks
    // ========================================================================
    task automatic write_block(input logic [19:0] a);
        logic [31:0] old_w [8];
        logic [31:0] word_v;
        logic [7:0]  mask;
        for (int k = 0; k < 8; k++) begin
            old_w[k] = mem_peek(a + 20'(4 * k));
        end
        push_addr(a);
        repeat (32) tx_bytes.push_back(8'($urandom));
        mask = 8'($urandom);
        tx_bytes.push_back(mask);
        send_frame();
        wait_not_busy();
        for (int k = 0; k < 8; k++) begin
            word_v = {tx_bytes[7 + 4 * k], tx_bytes[6 + 4 * k],
                      tx_bytes[5 + 4 * k], tx_bytes[4 + 4 * k]};
            check_word(a + 20'(4 * k), mask[k] ? word_v : old_w[k]);
        end
    endtask

    task automatic read_block(input logic [19:0] a);
        logic [31:0] exp_w;
        push_addr(a);
        send_frame();
        assert (mcu_dout[blit_pkg::status_busy_bit])
            else abort_run("status byte not busy after a read command");
        wait_not_busy();
        assert (mcu_dout == 8'(1 << blit_pkg::status_ready_bit)) else begin
            abort_run($sformatf("Mismatch mcu_dout: got %02h expected %02h",
                                mcu_dout, 8'(1 << blit_pkg::status_ready_bit)));
        end
        read_back();
        for (int i = 0; i < 32; i++) begin
            exp_w = mem_peek(a + 20'(4 * (i / 4)));
            assert (rx_bytes[i] == exp_w[8 * (i % 4) +: 8]) else begin
                abort_run($sformatf("Mismatch mcu_dout byte %0d: got %02h expected %02h",
                                    i, rx_bytes[i], exp_w[8 * (i % 4) +: 8]));
            end
        end
    endtask

    task automatic font_row(input logic [19:0] a);
        logic [15:0] fc;
        logic [15:0] bc;
        logic [15:0] pix [8];
        logic [31:0] old_w [8];
        logic [7:0]  glyph;
        logic [7:0]  mask;
        fc = 16'($urandom);
        bc = 16'($urandom);
        push_addr(a);                   // colour frame keeps an address slot
        tx_bytes.push_back(fc[7:0]);
        tx_bytes.push_back(fc[15:8]);
        tx_bytes.push_back(bc[7:0]);
        tx_bytes.push_back(bc[15:8]);
        send_frame();
        wait_not_busy();
        glyph = 8'($urandom);
        mask  = {4'h0, 4'($urandom)} | 8'h01;   // beats 4..7 carry stale words
        for (int k = 0; k < 8; k++) begin
            old_w[k] = mem_peek(a + 20'(4 * k));
        end
        push_addr(a);
        tx_bytes.push_back(glyph);
        tx_bytes.push_back(mask);
        send_frame();
        wait_not_busy();
        for (int j = 0; j < 8; j++) begin
            pix[j] = glyph[7 - j] ? fc : bc;
        end
        for (int k = 0; k < 8; k++) begin
            if (k < 4 && mask[k]) begin
                check_word(a + 20'(4 * k), {pix[2 * k + 1], pix[2 * k]});
            end else begin
                check_word(a + 20'(4 * k), old_w[k]);
            end
        end
    endtask

    initial begin : stimulus
        logic [19:0] a;
        void'($urandom(30985));
        mcu_din = 8'h00;
        mcu_clk = 1'b0;
        mcu_dir = 1'b0;
        rst_n   = 1'b0;
        repeat (8) @(negedge dma_clk);
        rst_n = 1'b1;
        assert (mcu_dout == 8'h00) else begin
            abort_run($sformatf("Mismatch mcu_dout: got %02h expected 00", mcu_dout));
        end
        read_block(20'($urandom) & 20'hfffe0);  // request waits for mem_init_calib
        repeat (3) begin
            a = 20'($urandom) & 20'hfffe0;  // burst stays inside 20 bits
            write_block(a);
            read_block(a);
        end
        font_row(20'($urandom) & 20'hfffe0);
        $display("Test completed successfully");
        $finish;
    end

endmodule

/* verilog/blit_top.sv */
`timescale 1ns/1ps

module blit_top (
    input  logic                          dma_clk,
    input  logic                          rst_n,
    input  logic [7:0]                    mcu_din,
    input  logic                          mcu_clk,
    input  logic                          mcu_dir,
    input  logic [blit_pkg::word_w-1:0]   mem_rd_data,
    input  logic                          mem_rd_data_valid,
    input  logic                          mem_init_calib,
    output logic [7:0]                    mcu_dout,
    output logic                          mem_cmd,
    output logic                          mem_cmd_en,
    output logic [blit_pkg::addr_w-1:0]   mem_addr,
    output logic [blit_pkg::word_w-1:0]   mem_wr_data,
    output logic [blit_pkg::word_w/8-1:0] mem_data_mask
);

    mcu_evt_if evt ();
    font_if    fnt ();
    mem_req_if req ();

    mcu_port u_mcu_port (
        .dma_clk (dma_clk),
        .rst_n   (rst_n),
        .mcu_clk (mcu_clk),
        .mcu_dir (mcu_dir),
        .mcu_din (mcu_din),
        .evt     (evt.src)
    );

    command_seq u_command_seq (
        .dma_clk  (dma_clk),
        .rst_n    (rst_n),
        .mcu_dout (mcu_dout),
        .evt      (evt.dst),
        .fnt      (fnt.seq),
        .req      (req.seq)
    );

    font_expander u_font_expander (
        .dma_clk (dma_clk),
        .rst_n   (rst_n),
        .fnt     (fnt.exp)
    );

    mem_cmd_issuer u_mem_cmd_issuer (
        .dma_clk           (dma_clk),
        .rst_n             (rst_n),
        .mem_init_calib    (mem_init_calib),
        .mem_rd_data_valid (mem_rd_data_valid),
        .mem_rd_data       (mem_rd_data),
        .mem_cmd           (mem_cmd),
        .mem_cmd_en        (mem_cmd_en),
        .mem_addr          (mem_addr),
        .mem_wr_data       (mem_wr_data),
        .mem_data_mask     (mem_data_mask),
        .req               (req.iss)
    );

endmodule

/* verilog/command_seq.sv */
`timescale 1ns/1ps

module command_seq (
    input  logic       dma_clk,
    input  logic       rst_n,
    output logic [7:0] mcu_dout,
    mcu_evt_if.dst     evt,
    font_if.seq        fnt,
    mem_req_if.seq     req
);

    blit_pkg::buf_word_u  buf_q [blit_pkg::buf_words];
    blit_pkg::seq_state_e state;
    logic [5:0]  ptr;       // byte pointer into buf_q
    logic [1:0]  over;      // bytes taken at the mask slot, saturates at 2
    logic [15:0] fcolor;
    logic [15:0] bcolor;
    logic [7:0]  wmask;
    logic [7:0]  status;
    logic        busy;
    logic        byte_in;
    logic [5:0]  byte_cnt;

    assign byte_in  = evt.clk_rise & evt.dir;
    assign byte_cnt = ptr + 6'(over);
    assign busy     = state inside {blit_pkg::st_load, blit_pkg::st_mem_wait,
                                    blit_pkg::st_font_run};

    assign req.req_addr  = buf_q[0].word[blit_pkg::addr_w-1:0];
    assign req.req_mask  = wmask;
    assign req.beat_word = buf_q[4'(req.beat_idx) + 4'd1].word;
    assign fnt.bits      = buf_q[1].bytes[0];   // glyph row of a font command
    assign fnt.fcolor    = fcolor;
    assign fnt.bcolor    = bcolor;

    // ========================================================================
    // command sequencer
    // ========================================================================
    always_ff @(posedge dma_clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= blit_pkg::st_idle;
            ptr           <= '0;
            over          <= '0;
            fcolor        <= blit_pkg::fcolor_reset;
            bcolor        <= blit_pkg::bcolor_reset;
            wmask         <= '0;
            req.req_write <= 1'b0;
            req.req_read  <= 1'b0;
            fnt.start     <= 1'b0;
        end else begin
            fnt.start <= 1'b0;
            case (state)
                blit_pkg::st_idle: begin
                    if (evt.dir_rise) begin
                        state <= blit_pkg::st_load;
                        ptr   <= '0;
                        over  <= '0;
                    end
                end
                blit_pkg::st_load: begin
                    if (byte_in) begin
                        if (ptr < 6'(blit_pkg::readout_end)) begin
                            ptr <= ptr + 6'd1;
                        end else begin
                            wmask <= evt.din;           // byte 36 of a write
                            if (over != 2'd2) begin
                                over <= over + 2'd1;
                            end
                        end
                    end
                    if (evt.dir_fall) begin
                        state <= blit_pkg::st_idle;     // unknown counts dropped
                        case (byte_cnt)
                            6'(blit_pkg::n_write_bytes): begin
                                req.req_write <= 1'b1;
                                state         <= blit_pkg::st_mem_wait;
                            end
                            6'(blit_pkg::n_read_bytes): begin
                                req.req_read <= 1'b1;
                                state        <= blit_pkg::st_mem_wait;
                            end
                            6'(blit_pkg::n_color_bytes): begin
                                fcolor <= buf_q[1].pix[0];
                                bcolor <= buf_q[1].pix[1];
                            end
                            6'(blit_pkg::n_font_bytes): begin
                                wmask     <= buf_q[1].bytes[1];
                                fnt.start <= 1'b1;
                                state     <= blit_pkg::st_font_run;
                            end
                            default: ;
                        endcase
                    end
                end
                blit_pkg::st_mem_wait: begin
                    if (req.done) begin
                        req.req_write <= 1'b0;
                        req.req_read  <= 1'b0;
                        state <= req.req_read ? blit_pkg::st_read_ack : blit_pkg::st_idle;
                    end
                end
                blit_pkg::st_font_run: begin
                    if (fnt.done) begin
                        req.req_write <= 1'b1;          // pixels go out as a write
                        state         <= blit_pkg::st_mem_wait;
                    end
                end
                blit_pkg::st_read_ack: begin
                    if (evt.clk_rise) begin
                        ptr   <= 6'(blit_pkg::readout_first);
                        state <= blit_pkg::st_readout;
                    end
                end
                blit_pkg::st_readout: begin
                    if (evt.clk_rise) begin
                        ptr <= ptr + 6'd1;
                        if (ptr == 6'(blit_pkg::readout_end - 1)) begin
                            state <= blit_pkg::st_idle;
                        end
                    end
                end
                default: state <= blit_pkg::st_idle;
            endcase
        end
    end

    // buffer writes from the mcu, font and memory paths
    always_ff @(posedge dma_clk) begin
        if (state == blit_pkg::st_load && byte_in && ptr < 6'(blit_pkg::readout_end)) begin
            buf_q[ptr[5:2]].bytes[ptr[1:0]] <= evt.din;
        end
        if (fnt.wr_en) begin
            buf_q[fnt.wr_idx].pix <= fnt.wr_pix;
        end
        if (req.cap_en) begin
            buf_q[4'(req.cap_idx) + 4'd1].word <= req.cap_word;
        end
    end

    always_comb begin
        status = '0;
        status[blit_pkg::status_busy_bit]  = busy;
        status[blit_pkg::status_ready_bit] = (state == blit_pkg::st_read_ack);
    end

    assign mcu_dout = (state == blit_pkg::st_readout) ? buf_q[ptr[5:2]].bytes[ptr[1:0]]
                                                      : status;

    a_ptr_range: assert property (@(posedge dma_clk) disable iff (!rst_n)
        ptr <= 6'(blit_pkg::readout_end));

endmodule

/* verilog/mem_cmd_issuer.sv */
`timescale 1ns/1ps

module mem_cmd_issuer (
    input  logic                          dma_clk,
    input  logic                          rst_n,
    input  logic                          mem_init_calib,
    input  logic                          mem_rd_data_valid,
    input  logic [blit_pkg::word_w-1:0]   mem_rd_data,
    output logic                          mem_cmd,
    output logic                          mem_cmd_en,
    output logic [blit_pkg::addr_w-1:0]   mem_addr,
    output logic [blit_pkg::word_w-1:0]   mem_wr_data,
    output logic [blit_pkg::word_w/8-1:0] mem_data_mask,
    mem_req_if.iss                        req
);

    logic [$clog2(blit_pkg::guard_cycles+1)-1:0] guard_cnt;
    logic [$clog2(blit_pkg::burst_len)-1:0]      beat_cnt;
    logic                                         active;     // burst in flight
    logic                                         beat_step;
    logic                                         issue;

    // no new command while done is still visible to the sequencer
    assign issue = (req.req_write | req.req_read) & ~active & ~req.done
                 & mem_init_calib & (guard_cnt == '0) & ~mem_rd_data_valid;
    assign beat_step = active & (mem_cmd | mem_rd_data_valid);

    assign mem_addr      = req.req_addr;
    assign mem_wr_data   = req.beat_word;
    assign mem_data_mask = req.req_mask[beat_cnt] ? '0 : '1;
    assign req.beat_idx  = beat_cnt;
    assign req.cap_en    = active & ~mem_cmd & mem_rd_data_valid;
    assign req.cap_idx   = beat_cnt;
    assign req.cap_word  = mem_rd_data;

    always_ff @(posedge dma_clk or negedge rst_n) begin
        if (!rst_n) begin
            guard_cnt  <= '0;
            beat_cnt   <= '0;
            active     <= 1'b0;
            mem_cmd    <= 1'b0;
            mem_cmd_en <= 1'b0;
            req.done   <= 1'b0;
        end else begin
            mem_cmd_en <= issue;
            req.done   <= 1'b0;
            if (mem_cmd_en) begin
                guard_cnt <= $bits(guard_cnt)'(blit_pkg::guard_cycles);
            end else if (guard_cnt != '0) begin
                guard_cnt <= guard_cnt - 1'b1;
            end
            if (issue) begin
                active   <= 1'b1;
                mem_cmd  <= req.req_write;      // 1 write, 0 read
                beat_cnt <= '0;
            end else if (beat_step) begin
                beat_cnt <= beat_cnt + 1'b1;
                if (beat_cnt == $bits(beat_cnt)'(blit_pkg::burst_len - 1)) begin
                    active   <= 1'b0;
                    req.done <= 1'b1;
                end
            end
        end
    end

    a_guard: assert property (@(posedge dma_clk) disable iff (!rst_n)
        mem_cmd_en |-> guard_cnt == '0);
    a_done_pulse: assert property (@(posedge dma_clk) disable iff (!rst_n)
        req.done |=> !req.done);

endmodule

/* verilog/font_expander.sv */
`timescale 1ns/1ps

module font_expander (
    input  logic dma_clk,
    input  logic rst_n,
    font_if.exp  fnt
);

    logic [7:0]  bits_q;    // glyph row, msb first
    logic [2:0]  pix_cnt;
    logic        run;
    logic [15:0] pix_lo;    // earlier pixel of the pair
    logic [15:0] cur_pix;

    assign cur_pix = bits_q[7] ? fnt.fcolor : fnt.bcolor;

    always_ff @(posedge dma_clk or negedge rst_n) begin
        if (!rst_n) begin
            run       <= 1'b0;
            pix_cnt   <= '0;
            fnt.wr_en <= 1'b0;
            fnt.done  <= 1'b0;
        end else begin
            fnt.wr_en <= run & pix_cnt[0];          // every second pixel
            fnt.done  <= run & (pix_cnt == 3'd7);
            if (fnt.start) begin
                run     <= 1'b1;
                pix_cnt <= '0;
            end else if (run) begin
                pix_cnt <= pix_cnt + 3'd1;
                if (pix_cnt == 3'd7) begin
                    run <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge dma_clk) begin
        if (fnt.start) begin
            bits_q <= fnt.bits;
        end else begin
            bits_q <= {bits_q[6:0], 1'b0};
        end
        if (run && !pix_cnt[0]) begin
            pix_lo <= cur_pix;
        end
        if (run && pix_cnt[0]) begin
            fnt.wr_idx <= 4'(pix_cnt[2:1]) + 4'd1;  // buffer words 1..4
            fnt.wr_pix <= {cur_pix, pix_lo};
        end
    end

    // the sequencer waits for done before another glyph
    a_no_restart: assert property (@(posedge dma_clk) disable iff (!rst_n)
        run |-> !fnt.start);

endmodule

/* verilog/mcu_port.sv */
`timescale 1ns/1ps

module mcu_port (
    input  logic       dma_clk,
    input  logic       rst_n,
    input  logic       mcu_clk,
    input  logic       mcu_dir,
    input  logic [7:0] mcu_din,
    mcu_evt_if.src     evt
);

    logic [2:0] clk_sync;   // two sync stages plus delayed copy
    logic [2:0] dir_sync;
    logic       clk_edge;

    assign clk_edge = clk_sync[1] & ~clk_sync[2];
    assign evt.dir  = dir_sync[2];     // lines up with the dir pulses

    always_ff @(posedge dma_clk or negedge rst_n) begin
        if (!rst_n) begin
            clk_sync     <= '0;
            dir_sync     <= '0;
            evt.clk_rise <= 1'b0;
            evt.dir_rise <= 1'b0;
            evt.dir_fall <= 1'b0;
        end else begin
            clk_sync     <= {clk_sync[1:0], mcu_clk};
            dir_sync     <= {dir_sync[1:0], mcu_dir};
            evt.clk_rise <= clk_edge;
            evt.dir_rise <= dir_sync[1] & ~dir_sync[2];
            evt.dir_fall <= ~dir_sync[1] & dir_sync[2];
        end
    end

    // data is stable since the falling mcu_clk edge
    always_ff @(posedge dma_clk) begin
        if (clk_edge) begin
            evt.din <= mcu_din;
        end
    end

endmodule

/* verilog/blit_ifs.sv */
`timescale 1ns/1ps

interface mcu_evt_if;
    logic       dir;
    logic       clk_rise;
    logic       dir_rise;
    logic       dir_fall;
    logic [7:0] din;        // byte sampled with clk_rise

    modport src (output dir, clk_rise, dir_rise, dir_fall, din);
    modport dst (input  dir, clk_rise, dir_rise, dir_fall, din);
endinterface

interface font_if;
    logic                                     start;
    logic [7:0]                               bits;
    logic [15:0]                              fcolor;
    logic [15:0]                              bcolor;
    logic                                     wr_en;
    logic [$clog2(blit_pkg::buf_words)-1:0]   wr_idx;   // words 1..4
    logic [1:0][15:0]                         wr_pix;
    logic                                     done;

    modport seq (output start, bits, fcolor, bcolor, input  wr_en, wr_idx, wr_pix, done);
    modport exp (input  start, bits, fcolor, bcolor, output wr_en, wr_idx, wr_pix, done);
endinterface

interface mem_req_if;
    logic                                   req_write;
    logic                                   req_read;
    logic [blit_pkg::addr_w-1:0]            req_addr;
    logic [blit_pkg::burst_len-1:0]         req_mask;   // bit k enables beat k
    logic [blit_pkg::word_w-1:0]            beat_word;
    logic [$clog2(blit_pkg::burst_len)-1:0] beat_idx;
    logic                                   cap_en;
    logic [$clog2(blit_pkg::burst_len)-1:0] cap_idx;
    logic [blit_pkg::word_w-1:0]            cap_word;
    logic                                   done;

    modport seq (output req_write, req_read, req_addr, req_mask, beat_word,
                 input  beat_idx, cap_en, cap_idx, cap_word, done);
    modport iss (input  req_write, req_read, req_addr, req_mask, beat_word,
                 output beat_idx, cap_en, cap_idx, cap_word, done);
endinterface

/* verilog/blit_pkg.sv */
package blit_pkg;

    // ========================================================================
    // sizes and timing
    // ========================================================================
    localparam int addr_w       = 20;
    localparam int word_w       = 32;
    localparam int buf_words    = 9;     // word 0 address, 1..8 data
    localparam int burst_len    = 8;
    localparam int guard_cycles = 16;    // quiet window after cmd_en

    // byte counts that select a command
    localparam int n_write_bytes = 37;
    localparam int n_read_bytes  = 4;
    localparam int n_color_bytes = 8;
    localparam int n_font_bytes  = 6;

    localparam int readout_first = 4;    // first data byte
    localparam int readout_end   = 36;

    localparam int status_busy_bit  = 0;
    localparam int status_ready_bit = 1;

    localparam logic [15:0] fcolor_reset = 16'hffff;
    localparam logic [15:0] bcolor_reset = 16'h0000;

    // ========================================================================
    // buffer word and sequencer states
    // ========================================================================
    typedef union packed {
        logic [word_w-1:0]        word;
        logic [word_w/8-1:0][7:0] bytes;  // byte 0 lowest
        logic [1:0][word_w/2-1:0] pix;    // rgb565 pair with pixel 0 low
    } buf_word_u;

    typedef enum logic [2:0] {
        st_idle,
        st_load,
        st_mem_wait,
        st_font_run,
        st_read_ack,
        st_readout
    } seq_state_e;

endpackage
